/* rtl/fabric_pkg.sv */
`default_nettype none

package fabric_pkg;

    // bus geometry
    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;

    // port counts
    localparam int num_masters = 8;  // cpu0..3, dma0..1, debug slave, from lsdom
    localparam int num_slaves  = 6;

    localparam int mst_idx_width = 3;
    localparam int slv_idx_width = 3;

    typedef logic [addr_width-1:0]    addr_t;
    typedef logic [data_width-1:0]    data_t;
    typedef logic [strb_width-1:0]    strb_t;
    typedef logic [mst_idx_width-1:0] mst_idx_t;
    typedef logic [slv_idx_width-1:0] slv_idx_t;

    // address map, half-open regions [base, end)
    localparam addr_t region_base [num_slaves] = '{
        32'h0000_0000,  // mem0
        32'h0008_0000,  // mem1
        32'h0009_0400,  // hsp0
        32'h0009_0000,  // hsp1
        32'h0200_0400,  // debug
        32'h0100_0000   // to_lsdom
    };

    localparam addr_t region_end [num_slaves] = '{
        32'h0008_0000,
        32'h0008_4000,
        32'h0009_0800,
        32'h0009_0400,
        32'h0200_0800,
        32'h0200_0000
    };

    // one transaction in flight at a time
    typedef enum logic [2:0] {
        xfer_idle,
        xfer_grant,
        xfer_req,
        xfer_resp,
        xfer_err
    } xfer_state_t;

endpackage

`default_nettype wire

/* rtl/fabric_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module fabric_decoder (
    input  fabric_pkg::addr_t     addr,
    output fabric_pkg::slv_idx_t  slave,
    output fabric_pkg::addr_t     offset,
    output logic                  miss
);
    import fabric_pkg::*;

    logic hit;

    always_comb begin
        hit    = 1'b0;
        slave  = '0;
        offset = '0;
        for (int r = 0; r < num_slaves; r++) begin
            // first matching region wins
            if (!hit && addr >= region_base[r] && addr < region_end[r]) begin
                hit    = 1'b1;
                slave  = slv_idx_t'(r);
                offset = addr - region_base[r];
            end
        end
    end

    assign miss = !hit;

endmodule

`default_nettype wire

/* rtl/fabric_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module fabric_arbiter (
    input  logic                                seq,
    input  logic                                reset,
    input  logic [fabric_pkg::num_masters-1:0]  req_valid,
    input  logic                                pause_req,
    input  logic                                grant_release,
    output logic                                grant_valid,
    output fabric_pkg::mst_idx_t                grant_idx,
    output logic                                pause_ack
);
    import fabric_pkg::*;

    mst_idx_t ptr;       // highest priority master
    mst_idx_t next_ptr;
    mst_idx_t pick_idx;
    logic     pick_found;

    // first valid request at or after ptr
    always_comb begin
        int cand;
        pick_idx   = ptr;
        pick_found = 1'b0;
        for (int i = 0; i < num_masters; i++) begin
            cand = (int'(ptr) + i) % num_masters;
            if (!pick_found && req_valid[cand]) begin
                pick_idx   = mst_idx_t'(cand);
                pick_found = 1'b1;
            end
        end
    end

    // rotate past the master just served
    always_comb begin
        if (grant_idx == mst_idx_t'(num_masters - 1)) begin
            next_ptr = '0;
        end else begin
            next_ptr = grant_idx + 1'b1;
        end
    end

    always_ff @(posedge seq) begin
        if (reset) begin
            grant_valid <= 1'b0;
            grant_idx   <= '0;
            ptr         <= '0;
        end else if (grant_valid) begin
            if (grant_release) begin
                grant_valid <= 1'b0;
                ptr         <= next_ptr;
            end
        end else if (!pause_req && pick_found) begin
            grant_valid <= 1'b1;
            grant_idx   <= pick_idx;
        end
    end

    // no grant means the transfer side is back in idle
    assign pause_ack = pause_req && !grant_valid;

endmodule

`default_nettype wire

/* rtl/fabric_xfer_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fabric_xfer_ctrl (
    input  logic                                                seq,
    input  logic                                                reset,

    input  logic                                                grant_valid,
    input  fabric_pkg::mst_idx_t                                grant_idx,
    output logic                                                grant_release,
    output fabric_pkg::addr_t                                   sel_addr,

    input  fabric_pkg::slv_idx_t                                dec_slave,
    input  fabric_pkg::addr_t                                   dec_offset,
    input  logic                                                dec_miss,

    input  logic [fabric_pkg::num_masters-1:0]                  mst_req_valid,
    output logic [fabric_pkg::num_masters-1:0]                  mst_req_ready,
    input  logic [fabric_pkg::num_masters-1:0]                  mst_req_write,
    input  fabric_pkg::addr_t [fabric_pkg::num_masters-1:0]     mst_req_addr,
    input  fabric_pkg::data_t [fabric_pkg::num_masters-1:0]     mst_req_data,
    input  fabric_pkg::strb_t [fabric_pkg::num_masters-1:0]     mst_req_strb,
    output logic [fabric_pkg::num_masters-1:0]                  mst_resp_valid,
    input  logic [fabric_pkg::num_masters-1:0]                  mst_resp_ready,
    output fabric_pkg::data_t [fabric_pkg::num_masters-1:0]     mst_resp_data,
    output logic [fabric_pkg::num_masters-1:0]                  mst_resp_err,

    output logic [fabric_pkg::num_slaves-1:0]                   slv_req_valid,
    input  logic [fabric_pkg::num_slaves-1:0]                   slv_req_ready,
    output logic [fabric_pkg::num_slaves-1:0]                   slv_req_write,
    output fabric_pkg::addr_t [fabric_pkg::num_slaves-1:0]      slv_req_addr,
    output fabric_pkg::data_t [fabric_pkg::num_slaves-1:0]      slv_req_data,
    output fabric_pkg::strb_t [fabric_pkg::num_slaves-1:0]      slv_req_strb,
    input  logic [fabric_pkg::num_slaves-1:0]                   slv_resp_valid,
    output logic [fabric_pkg::num_slaves-1:0]                   slv_resp_ready,
    input  fabric_pkg::data_t [fabric_pkg::num_slaves-1:0]      slv_resp_data,
    input  logic [fabric_pkg::num_slaves-1:0]                   slv_resp_err
);
    import fabric_pkg::*;

    xfer_state_t state;
    xfer_state_t state_next;

    // routing held for the whole transaction
    mst_idx_t cur_mst;
    slv_idx_t cur_slv;
    addr_t    cur_offset;
    logic     cur_miss;

    assign sel_addr = mst_req_addr[grant_idx];  // feeds the decoder

    always_ff @(posedge seq) begin
        if (reset) begin
            state <= xfer_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge seq) begin
        if (state == xfer_grant) begin
            cur_mst    <= grant_idx;
            cur_slv    <= dec_slave;
            cur_offset <= dec_offset;
            cur_miss   <= dec_miss;
        end
    end

    always_comb begin
        state_next     = state;
        grant_release  = 1'b0;
        mst_req_ready  = '0;
        mst_resp_valid = '0;
        mst_resp_data  = '0;
        mst_resp_err   = '0;
        slv_req_valid  = '0;
        slv_resp_ready = '0;

        // payload goes to every slave, only valid is steered
        for (int s = 0; s < num_slaves; s++) begin
            slv_req_write[s] = mst_req_write[cur_mst];
            slv_req_addr[s]  = cur_offset;
            slv_req_data[s]  = mst_req_data[cur_mst];
            slv_req_strb[s]  = mst_req_strb[cur_mst];
        end

        case (state)
            xfer_idle: begin
                if (grant_valid) begin
                    state_next = xfer_grant;
                end
            end
            xfer_grant: begin
                state_next = xfer_req;  // decode latched this cycle
            end
            xfer_req: begin
                if (cur_miss) begin
                    // swallow the request, no slave involved
                    mst_req_ready[cur_mst] = 1'b1;
                    if (mst_req_valid[cur_mst]) begin
                        state_next = xfer_err;
                    end
                end else begin
                    slv_req_valid[cur_slv] = mst_req_valid[cur_mst];
                    mst_req_ready[cur_mst] = slv_req_ready[cur_slv];
                    if (mst_req_valid[cur_mst] && slv_req_ready[cur_slv]) begin
                        state_next = xfer_resp;
                    end
                end
            end
            xfer_resp: begin
                mst_resp_valid[cur_mst] = slv_resp_valid[cur_slv];
                mst_resp_data[cur_mst]  = slv_resp_data[cur_slv];
                mst_resp_err[cur_mst]   = slv_resp_err[cur_slv];
                slv_resp_ready[cur_slv] = mst_resp_ready[cur_mst];
                if (slv_resp_valid[cur_slv] && mst_resp_ready[cur_mst]) begin
                    grant_release = 1'b1;
                    state_next    = xfer_idle;
                end
            end
            xfer_err: begin
                mst_resp_valid[cur_mst] = 1'b1;
                mst_resp_err[cur_mst]   = 1'b1;  // data stays zero
                if (mst_resp_ready[cur_mst]) begin
                    grant_release = 1'b1;
                    state_next    = xfer_idle;
                end
            end
            default: begin
                state_next = xfer_idle;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/fabric_hsdom.sv */
`timescale 1ns/1ps
`default_nettype none

module fabric_hsdom (
    input  logic                                                seq,
    input  logic                                                reset,
    input  logic                                                pause_req,
    output logic                                                pause_ack,

    input  logic [fabric_pkg::num_masters-1:0]                  mst_req_valid,
    output logic [fabric_pkg::num_masters-1:0]                  mst_req_ready,
    input  logic [fabric_pkg::num_masters-1:0]                  mst_req_write,
    input  fabric_pkg::addr_t [fabric_pkg::num_masters-1:0]     mst_req_addr,
    input  fabric_pkg::data_t [fabric_pkg::num_masters-1:0]     mst_req_data,
    input  fabric_pkg::strb_t [fabric_pkg::num_masters-1:0]     mst_req_strb,
    output logic [fabric_pkg::num_masters-1:0]                  mst_resp_valid,
    input  logic [fabric_pkg::num_masters-1:0]                  mst_resp_ready,
    output fabric_pkg::data_t [fabric_pkg::num_masters-1:0]     mst_resp_data,
    output logic [fabric_pkg::num_masters-1:0]                  mst_resp_err,

    output logic [fabric_pkg::num_slaves-1:0]                   slv_req_valid,
    input  logic [fabric_pkg::num_slaves-1:0]                   slv_req_ready,
    output logic [fabric_pkg::num_slaves-1:0]                   slv_req_write,
    output fabric_pkg::addr_t [fabric_pkg::num_slaves-1:0]      slv_req_addr,
    output fabric_pkg::data_t [fabric_pkg::num_slaves-1:0]      slv_req_data,
    output fabric_pkg::strb_t [fabric_pkg::num_slaves-1:0]      slv_req_strb,
    input  logic [fabric_pkg::num_slaves-1:0]                   slv_resp_valid,
    output logic [fabric_pkg::num_slaves-1:0]                   slv_resp_ready,
    input  fabric_pkg::data_t [fabric_pkg::num_slaves-1:0]      slv_resp_data,
    input  logic [fabric_pkg::num_slaves-1:0]                   slv_resp_err
);
    import fabric_pkg::*;

    logic     grant_valid;
    mst_idx_t grant_idx;
    logic     grant_release;
    addr_t    sel_addr;
    slv_idx_t dec_slave;
    addr_t    dec_offset;
    logic     dec_miss;

    fabric_arbiter fabric_arbiter_i (
        .seq           (seq),
        .reset         (reset),
        .req_valid     (mst_req_valid),
        .pause_req     (pause_req),
        .grant_release (grant_release),
        .grant_valid   (grant_valid),
        .grant_idx     (grant_idx),
        .pause_ack     (pause_ack)
    );

    // address of the granted master only
    fabric_decoder fabric_decoder_i (
        .addr   (sel_addr),
        .slave  (dec_slave),
        .offset (dec_offset),
        .miss   (dec_miss)
    );

    fabric_xfer_ctrl fabric_xfer_ctrl_i (
        .seq            (seq),
        .reset          (reset),
        .grant_valid    (grant_valid),
        .grant_idx      (grant_idx),
        .grant_release  (grant_release),
        .sel_addr       (sel_addr),
        .dec_slave      (dec_slave),
        .dec_offset     (dec_offset),
        .dec_miss       (dec_miss),
        .mst_req_valid  (mst_req_valid),
        .mst_req_ready  (mst_req_ready),
        .mst_req_write  (mst_req_write),
        .mst_req_addr   (mst_req_addr),
        .mst_req_data   (mst_req_data),
        .mst_req_strb   (mst_req_strb),
        .mst_resp_valid (mst_resp_valid),
        .mst_resp_ready (mst_resp_ready),
        .mst_resp_data  (mst_resp_data),
        .mst_resp_err   (mst_resp_err),
        .slv_req_valid  (slv_req_valid),
        .slv_req_ready  (slv_req_ready),
        .slv_req_write  (slv_req_write),
        .slv_req_addr   (slv_req_addr),
        .slv_req_data   (slv_req_data),
        .slv_req_strb   (slv_req_strb),
        .slv_resp_valid (slv_resp_valid),
        .slv_resp_ready (slv_resp_ready),
        .slv_resp_data  (slv_resp_data),
        .slv_resp_err   (slv_resp_err)
    );

endmodule

`default_nettype wire

/* verif/fabric_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module fabric_checker #(
    parameter int num_pats = 34
) (
    input  logic                                            seq,
    input  logic                                            reset,
    input  logic                                            pause_req,
    input  logic                                            pause_ack,
    input  logic                                            done,
    input  logic [fabric_pkg::num_masters-1:0]              mst_resp_valid,
    input  logic [fabric_pkg::num_masters-1:0]              mst_resp_ready,
    input  fabric_pkg::data_t [fabric_pkg::num_masters-1:0] mst_resp_data,
    input  logic [fabric_pkg::num_masters-1:0]              mst_resp_err,
    input  logic [fabric_pkg::num_slaves-1:0]               slv_req_valid,
    input  logic [fabric_pkg::num_slaves-1:0]               slv_req_ready,
    output int                                              errors
);
    import fabric_pkg::*;

    logic [111:0] pats [num_pats];
    int           next_rec [num_masters];
    int           resp_seen;
    int           slv_seen;
    int           slv_expected;  // misses must never reach a slave

    function automatic int find_rec(input int m, input int from);
        for (int p = from; p < num_pats; p++) begin
            if (int'(pats[p][111:108]) == m) return p;
        end
        return -1;
    endfunction

    initial begin
        errors       = 0;
        resp_seen    = 0;
        slv_seen     = 0;
        slv_expected = 0;
        $readmemh("verif/fabric_patterns.hex", pats);
        for (int m = 0; m < num_masters; m++) next_rec[m] = 0;
        for (int p = 0; p < num_pats; p++) begin
            if (!pats[p][0]) slv_expected++;
        end
    end

    always @(posedge seq) begin
        int idx;
        if (!reset) begin
            if (pause_req && |mst_resp_valid) begin
                $display("Error at %0t: response while paused", $time);
                errors++;
            end
            // pause only ever starts with the fabric idle, so ack follows req
            if (pause_ack !== pause_req) begin
                $display("Error at %0t: pause_ack %b with pause_req %b",
                         $time, pause_ack, pause_req);
                errors++;
            end
            for (int m = 0; m < num_masters; m++) begin
                if (mst_resp_valid[m] && mst_resp_ready[m]) begin
                    idx = find_rec(m, next_rec[m]);
                    resp_seen++;
                    if (idx < 0) begin
                        $display("Error at %0t: master %0d extra response", $time, m);
                        errors++;
                    end else begin
                        if (mst_resp_data[m] !== pats[idx][35:4] ||
                            mst_resp_err[m] !== pats[idx][0]) begin
                            $display({"Error at %0t: master %0d record %0d ",
                                      "got %h err %b, want %h err %b"},
                                     $time, m, idx, mst_resp_data[m], mst_resp_err[m],
                                     pats[idx][35:4], pats[idx][0]);
                            errors++;
                        end
                        next_rec[m] = idx + 1;
                    end
                end
            end
            for (int s = 0; s < num_slaves; s++) begin
                if (slv_req_valid[s] && slv_req_ready[s]) slv_seen++;
            end
        end
    end

    // final totals
    always @(posedge done) begin
        if (resp_seen != num_pats) begin
            $display("Error at %0t: %0d of %0d responses seen", $time, resp_seen, num_pats);
            errors++;
        end
        if (slv_seen != slv_expected) begin
            $display("Error at %0t: %0d slave requests, want %0d", $time, slv_seen, slv_expected);
            errors++;
        end
    end

endmodule

`default_nettype wire

/* verif/fabric_hsdom_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fabric_hsdom_tb;
    import fabric_pkg::*;

    localparam int num_pats   = 34;
    localparam int wait_limit = 2000;  // cycles per handshake wait

    logic seq;
    logic reset;
    logic pause_req;
    logic pause_ack;
    logic done;

    logic [num_masters-1:0]      mst_req_valid;
    logic [num_masters-1:0]      mst_req_ready;
    logic [num_masters-1:0]      mst_req_write;
    addr_t [num_masters-1:0]     mst_req_addr;
    data_t [num_masters-1:0]     mst_req_data;
    strb_t [num_masters-1:0]     mst_req_strb;
    logic [num_masters-1:0]      mst_resp_valid;
    logic [num_masters-1:0]      mst_resp_ready;
    data_t [num_masters-1:0]     mst_resp_data;
    logic [num_masters-1:0]      mst_resp_err;

    logic [num_slaves-1:0]       slv_req_valid;
    logic [num_slaves-1:0]       slv_req_ready;
    logic [num_slaves-1:0]       slv_req_write;
    addr_t [num_slaves-1:0]      slv_req_addr;
    data_t [num_slaves-1:0]      slv_req_data;
    strb_t [num_slaves-1:0]      slv_req_strb;
    logic [num_slaves-1:0]       slv_resp_valid;
    logic [num_slaves-1:0]       slv_resp_ready;
    data_t [num_slaves-1:0]      slv_resp_data;
    logic [num_slaves-1:0]       slv_resp_err;

    // m_w_addr_data_strb_expdata_experr
    logic [111:0] pats [num_pats];
    int           timeouts;
    int           checker_errors;

    // slave storage keyed by {slave, offset}
    data_t        mem [bit [63:0]];
    logic [num_slaves-1:0] req_fire;
    logic [num_slaves-1:0] resp_fire;
    logic [num_slaves-1:0] pending;
    int           cnt [num_slaves];
    logic [31:0]  rng_state;

    fabric_hsdom fabric_hsdom_i (
        .seq            (seq),
        .reset          (reset),
        .pause_req      (pause_req),
        .pause_ack      (pause_ack),
        .mst_req_valid  (mst_req_valid),
        .mst_req_ready  (mst_req_ready),
        .mst_req_write  (mst_req_write),
        .mst_req_addr   (mst_req_addr),
        .mst_req_data   (mst_req_data),
        .mst_req_strb   (mst_req_strb),
        .mst_resp_valid (mst_resp_valid),
        .mst_resp_ready (mst_resp_ready),
        .mst_resp_data  (mst_resp_data),
        .mst_resp_err   (mst_resp_err),
        .slv_req_valid  (slv_req_valid),
        .slv_req_ready  (slv_req_ready),
        .slv_req_write  (slv_req_write),
        .slv_req_addr   (slv_req_addr),
        .slv_req_data   (slv_req_data),
        .slv_req_strb   (slv_req_strb),
        .slv_resp_valid (slv_resp_valid),
        .slv_resp_ready (slv_resp_ready),
        .slv_resp_data  (slv_resp_data),
        .slv_resp_err   (slv_resp_err)
    );

    fabric_checker #(.num_pats(num_pats)) fabric_checker_i (
        .seq            (seq),
        .reset          (reset),
        .pause_req      (pause_req),
        .pause_ack      (pause_ack),
        .done           (done),
        .mst_resp_valid (mst_resp_valid),
        .mst_resp_ready (mst_resp_ready),
        .mst_resp_data  (mst_resp_data),
        .mst_resp_err   (mst_resp_err),
        .slv_req_valid  (slv_req_valid),
        .slv_req_ready  (slv_req_ready),
        .errors         (checker_errors)
    );

    always #5 seq = ~seq;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // unwritten words read back as a pattern of slave and offset
    function automatic data_t read_word(input int s, input addr_t off);
        bit [63:0] key;
        key = {29'b0, 3'(s), off};
        if (mem.exists(key)) begin
            return mem[key];
        end
        return off ^ 32'ha000_0000 ^ {5'b0, 3'(s), 24'b0};
    endfunction

    // memory access at the request handshake, writes answer with zero
    always @(posedge seq) begin
        bit [63:0] key;
        data_t     word;
        req_fire  <= slv_req_valid & slv_req_ready;
        resp_fire <= slv_resp_valid & slv_resp_ready;
        for (int s = 0; s < num_slaves; s++) begin
            if (slv_req_valid[s] && slv_req_ready[s]) begin
                key  = {29'b0, 3'(s), slv_req_addr[s]};
                word = read_word(s, slv_req_addr[s]);
                if (slv_req_write[s]) begin
                    for (int b = 0; b < strb_width; b++) begin
                        if (slv_req_strb[s][b]) begin
                            word[8*b +: 8] = slv_req_data[s][8*b +: 8];
                        end
                    end
                    mem[key] = word;
                    slv_resp_data[s] <= '0;
                end else begin
                    slv_resp_data[s] <= word;
                end
            end
        end
    end

    // random ready and response delays per slave
    always @(negedge seq) begin
        if (reset) begin
            slv_req_ready  <= '0;
            slv_resp_valid <= '0;
            pending        <= '0;
        end else begin
            for (int s = 0; s < num_slaves; s++) begin
                if (req_fire[s]) begin
                    slv_req_ready[s] <= 1'b0;
                    pending[s]       <= 1'b1;
                    rng_state = xorshift(rng_state);
                    cnt[s]    = int'(rng_state % 4);
                end else if (resp_fire[s]) begin
                    slv_resp_valid[s] <= 1'b0;
                    pending[s]        <= 1'b0;
                    rng_state = xorshift(rng_state);
                    cnt[s]    = int'(rng_state % 4);
                end else if (pending[s] && !slv_resp_valid[s]) begin
                    if (cnt[s] == 0) slv_resp_valid[s] <= 1'b1;
                    else cnt[s] = cnt[s] - 1;
                end else if (!pending[s] && slv_req_valid[s] && !slv_req_ready[s]) begin
                    if (cnt[s] == 0) slv_req_ready[s] <= 1'b1;
                    else cnt[s] = cnt[s] - 1;
                end
            end
        end
    end

    // issues this master's records in file order
    task automatic run_master(input int m);
        int t;
        logic [111:0] rec;
        for (int p = 0; p < num_pats; p++) begin
            rec = pats[p];
            if (int'(rec[111:108]) == m) begin
                @(negedge seq);
                mst_req_valid[m] = 1'b1;
                mst_req_write[m] = rec[104];
                mst_req_addr[m]  = rec[103:72];
                mst_req_data[m]  = rec[71:40];
                mst_req_strb[m]  = rec[39:36];
                for (t = 0; t < wait_limit; t++) begin
                    @(posedge seq);
                    if (mst_req_ready[m]) break;
                end
                if (t == wait_limit) begin
                    $display("timeout: master %0d was never accepted on record %0d", m, p);
                    timeouts++;
                    return;
                end
                @(negedge seq);
                mst_req_valid[m]  = 1'b0;
                mst_resp_ready[m] = 1'b1;
                for (t = 0; t < wait_limit; t++) begin
                    @(posedge seq);
                    if (mst_resp_valid[m]) break;
                end
                if (t == wait_limit) begin
                    $display("timeout: master %0d got no response on record %0d", m, p);
                    timeouts++;
                    return;
                end
                @(negedge seq);
                mst_resp_ready[m] = 1'b0;
            end
        end
    endtask

    // hold the fabric paused while every master is already requesting
    task automatic run_pause();
        int t;
        for (t = 0; t < wait_limit; t++) begin
            @(posedge seq);
            if (pause_ack) break;
        end
        if (t == wait_limit) begin
            $display("timeout: pause_ack never rose while pause_req was high");
            timeouts++;
        end
        repeat (20) @(posedge seq);
        @(negedge seq);
        pause_req = 1'b0;
    endtask

    initial begin
        seq            = 1'b0;
        reset          = 1'b1;
        pause_req      = 1'b1;
        done           = 1'b0;
        timeouts       = 0;
        rng_state      = 32'h043630d5;
        mst_req_valid  = '0;
        mst_req_write  = '0;
        mst_req_addr   = '0;
        mst_req_data   = '0;
        mst_req_strb   = '0;
        mst_resp_ready = '0;
        slv_req_ready  = '0;
        slv_resp_valid = '0;
        slv_resp_data  = '0;
        slv_resp_err   = '0;
        req_fire       = '0;
        resp_fire      = '0;
        pending        = '0;
        for (int s = 0; s < num_slaves; s++) cnt[s] = 0;
        $readmemh("verif/fabric_patterns.hex", pats);

        repeat (16) @(posedge seq);
        @(negedge seq);
        reset = 1'b0;

        fork
            run_master(0);
            run_master(1);
            run_master(2);
            run_master(3);
            run_master(4);
            run_master(5);
            run_master(6);
            run_master(7);
            run_pause();
        join

        @(negedge seq);
        done = 1'b1;
        @(posedge seq);
        @(negedge seq);
        $display("errors: %0d, timeouts: %0d", checker_errors, timeouts);
        if (checker_errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/fabric_patterns.hex */
// master_write_addr_data_strb_expdata_experr, one transaction per line
// writes answer with data 0, unwritten words read as offset ^ a000_0000 ^ (slave << 24)
0_1_00000000_11110000_f_00000000_0
0_0_00000000_00000000_f_11110000_0
0_1_0007fffc_2222aaaa_f_00000000_0
0_0_0007fffc_00000000_f_2222aaaa_0
1_1_00080000_33330001_f_00000000_0
1_0_00080000_00000000_f_33330001_0
1_1_00083ffc_33330002_f_00000000_0
1_0_00083ffc_00000000_f_33330002_0
2_1_00090400_44440001_f_00000000_0
2_0_00090400_00000000_f_44440001_0
2_1_000907fc_44440002_f_00000000_0
2_0_000907fc_00000000_f_44440002_0
3_1_00090000_55550001_f_00000000_0
3_0_00090000_00000000_f_55550001_0
3_1_000903fc_55550002_f_00000000_0
3_0_000903fc_00000000_f_55550002_0
4_1_02000400_66660001_f_00000000_0
4_0_02000400_00000000_f_66660001_0
4_1_020007fc_66660002_f_00000000_0
4_0_020007fc_00000000_f_66660002_0
5_1_01000000_77770001_f_00000000_0
5_0_01000000_00000000_f_77770001_0
5_1_01fffffc_77770002_f_00000000_0
5_0_01fffffc_00000000_f_77770002_0
6_1_00090800_deadbeef_f_00000000_1
6_0_03000000_00000000_f_00000000_1
6_1_00080004_5a5a5a5a_f_00000000_0
6_0_00080004_00000000_f_5a5a5a5a_0
6_0_00000004_00000000_f_a0000004_0
7_1_00000100_12345678_f_00000000_0
7_1_00000100_aabbccdd_5_00000000_0
7_0_00000100_00000000_f_12bb56dd_0
7_1_00090010_ffffffff_2_00000000_0
7_0_00090010_00000000_f_a300ff10_0

/* files.f */
rtl/fabric_pkg.sv
rtl/fabric_decoder.sv
rtl/fabric_arbiter.sv
rtl/fabric_xfer_ctrl.sv
rtl/fabric_hsdom.sv
verif/fabric_checker.sv
verif/fabric_hsdom_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= fabric_hsdom_tb
RTL_TOP   ?= fabric_hsdom
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only rtl/fabric_pkg.sv rtl/fabric_decoder.sv \
		rtl/fabric_arbiter.sv rtl/fabric_xfer_ctrl.sv rtl/fabric_hsdom.sv \
		--top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
